//--- run_sim.sh
#!/usr/bin/env bash
# Compile the palette video testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_palette_video -o tb_palette_video

output=$(./obj_dir/tb_palette_video || true)
echo "$output"

if grep -q "Simulation PASSED" <<< "$output"; then
    exit 0
fi
exit 1

//--- sources.f
+incdir+verilog
verilog/video_pkg.sv
verilog/palette_ifs.sv
verilog/video_timing.sv
verilog/cpu_bus_port.sv
verilog/palette_arbiter.sv
verilog/palette_ram.sv
verilog/pixel_color_out.sv
verilog/palette_video_top.sv
test/video_checker.sv
test/tb_palette_video.sv

//--- test/tb_palette_video.sv
/*
    Testbench top: clock, reset, seeded random CPU and pixel stimulus,
    cycle limit and the run summary
*/

`timescale 1ns/1ps

`include "video_defines.svh"

module tb_palette_video
    import video_pkg::*;
;

localparam int FRAME_CLKS = 2 * `H_TOTAL * `V_TOTAL;     // Two clocks per pixel
localparam int LIMIT_CLKS = 2 * FRAME_CLKS + 94_496;     // Two frames plus CPU phases

localparam int PAL_SEL  = 0;
localparam int CTRL_SEL = 1;
localparam int NO_SEL   = 2;

logic               emu_mclk;
logic               emu_initrst_n;
logic [`CPU_AW-1:0] addr;
logic [7:0]         data_write;
logic               rd_n;
logic               wr_n;
logic               pal_cs_n;
logic               ctrl_cs_n;
logic [`PAL_AW-1:0] obj_pixel;

logic [7:0]         data_read;
logic               pixel_cen;
raster_cnt_t        hcount;
raster_cnt_t        vcount;
logic               csync_n;
logic               hsync_n;
logic               vsync_n;
logic               hblank_n;
logic               vblank_n;
logic [3:0]         video_r;
logic [3:0]         video_g;
logic [3:0]         video_b;

int                 errors;
int                 pix_checks;
int                 tb_errors = 0;
int                 tests_run = 0;
int                 tests_failed = 0;
int                 cycles = 0;
logic               pix_run = 1'b0;
logic [7:0]         entry_q [$];

palette_video_top i_palette_video_top (
    .i_EMU_MCLK     (emu_mclk       ),
    .i_EMU_INITRST_n(emu_initrst_n  ),
    .i_addr         (addr           ),
    .i_data_write   (data_write     ),
    .o_data_read    (data_read      ),
    .i_rd_n         (rd_n           ),
    .i_wr_n         (wr_n           ),
    .i_pal_cs_n     (pal_cs_n       ),
    .i_ctrl_cs_n    (ctrl_cs_n      ),
    .i_obj_pixel    (obj_pixel      ),
    .o_pixel_cen    (pixel_cen      ),
    .o_hcount       (hcount         ),
    .o_vcount       (vcount         ),
    .o_csync_n      (csync_n        ),
    .o_hsync_n      (hsync_n        ),
    .o_vsync_n      (vsync_n        ),
    .o_hblank_n     (hblank_n       ),
    .o_vblank_n     (vblank_n       ),
    .o_video_r      (video_r        ),
    .o_video_g      (video_g        ),
    .o_video_b      (video_b        )
);

video_checker u_video_checker (
    .i_EMU_MCLK     (emu_mclk       ),
    .i_EMU_INITRST_n(emu_initrst_n  ),
    .i_addr         (addr           ),
    .i_data_write   (data_write     ),
    .i_rd_n         (rd_n           ),
    .i_wr_n         (wr_n           ),
    .i_pal_cs_n     (pal_cs_n       ),
    .i_ctrl_cs_n    (ctrl_cs_n      ),
    .i_obj_pixel    (obj_pixel      ),
    .i_data_read    (data_read      ),
    .i_pixel_cen    (pixel_cen      ),
    .i_hcount       (hcount         ),
    .i_vcount       (vcount         ),
    .i_csync_n      (csync_n        ),
    .i_hsync_n      (hsync_n        ),
    .i_vsync_n      (vsync_n        ),
    .i_hblank_n     (hblank_n       ),
    .i_vblank_n     (vblank_n       ),
    .i_video_r      (video_r        ),
    .i_video_g      (video_g        ),
    .i_video_b      (video_b        ),
    .o_errors       (errors         ),
    .o_pix_checks   (pix_checks     )
);

//////////////////////////////////////////////////
//////  CLOCK, LIMIT, PIXEL SOURCE
////

initial
begin
    emu_mclk = 1'b0;
    forever #10 emu_mclk = ~emu_mclk;
end

always @(posedge emu_mclk)
begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT_CLKS)
    begin
        $display("Timeout: run still going after %0d clock cycles", cycles);
        $display("Simulation FAILED");
        $finish;
    end
end

// A fresh random index each clock for the enables to sample
task automatic drive_pixels();
    forever
    begin
        @(posedge emu_mclk);
        #2;
        if (pix_run)
            obj_pixel = 8'($urandom);
    end
endtask

task automatic cpu_write(input int target, input logic [`CPU_AW-1:0] a, input logic [7:0] d);
    @(posedge emu_mclk);
    #2;
    addr       = a;
    data_write = d;
    wr_n       = 1'b0;
    pal_cs_n   = (target != PAL_SEL);
    ctrl_cs_n  = (target != CTRL_SEL);
    @(posedge emu_mclk);        // Write lands on this edge
    #2;
    wr_n      = 1'b1;
    pal_cs_n  = 1'b1;
    ctrl_cs_n = 1'b1;
endtask

task automatic cpu_read(input int target, input logic [`CPU_AW-1:0] a);
    @(posedge emu_mclk);
    #2;
    addr      = a;
    rd_n      = 1'b0;
    pal_cs_n  = (target != PAL_SEL);
    ctrl_cs_n = (target != CTRL_SEL);
    repeat (2) @(posedge emu_mclk);     // Held past the clock of read latency
    #2;
    rd_n      = 1'b1;
    pal_cs_n  = 1'b1;
    ctrl_cs_n = 1'b1;
endtask

task automatic run_enables(input int n);
    repeat (n)
    begin
        do
            @(negedge emu_mclk);
        while (pixel_cen !== 1'b1);
    end
endtask

task automatic wait_line(input int line);
    do
        @(negedge emu_mclk);
    while (vcount != `CNT_W'(line));
endtask

task automatic end_test(input string name, input int mark);
    int n;
    n = errors + tb_errors - mark;
    tests_run++;
    if (n == 0)
        $display("Test %0d %s: ok", tests_run, name);
    else
    begin
        tests_failed++;
        $display("Test %0d %s: %0d errors", tests_run, name, n);
    end
endtask

//////////////////////////////////////////////////
//////  TEST SEQUENCE
////

initial
begin
    int         mark;
    int         pix_mark;
    logic [7:0] ent;

    void'($urandom(63));
    emu_initrst_n = 1'b0;
    addr          = '0;
    data_write    = 8'h00;
    rd_n          = 1'b1;
    wr_n          = 1'b1;
    pal_cs_n      = 1'b1;
    ctrl_cs_n     = 1'b1;
    obj_pixel     = 8'h00;

    fork
        drive_pixels();
    join_none

    repeat (4) @(posedge emu_mclk);
    #2;
    emu_initrst_n = 1'b1;
    mark = errors + tb_errors;
    repeat (2) @(negedge emu_mclk);
    end_test("reset state", mark);

    // Counts start at zero, so the next return to line 0 closes a frame
    mark = errors + tb_errors;
    wait_line(`V_TOTAL - 1);
    wait_line(0);
    end_test("raster frame", mark);

    mark = errors + tb_errors;
    for (int i = 0; i < 64; i++)
    begin
        ent = 8'($urandom);
        entry_q.push_back(ent);
        cpu_write(PAL_SEL, {ent, 1'b0}, 8'($urandom));
        cpu_write(PAL_SEL, {ent, 1'b1}, 8'($urandom));
    end
    foreach (entry_q[i])
    begin
        cpu_read(PAL_SEL, {entry_q[i], 1'b0});
        cpu_read(PAL_SEL, {entry_q[i], 1'b1});
    end
    repeat (4) cpu_read(NO_SEL, 9'($urandom));
    end_test("palette byte access", mark);

    mark = errors + tb_errors;
    for (int i = 0; i < 256; i++)
    begin
        cpu_write(PAL_SEL, {8'(i), 1'b0}, 8'($urandom));
        cpu_write(PAL_SEL, {8'(i), 1'b1}, 8'($urandom));
    end
    pix_mark = pix_checks;
    pix_run  = 1'b1;
    run_enables(`H_TOTAL * `V_TOTAL);
    if (pix_checks == pix_mark)
    begin
        tb_errors++;
        $display("No visible pixel colour was compared during the lookup frame");
    end
    end_test("colour lookup", mark);

    mark = errors + tb_errors;
    cpu_write(CTRL_SEL, 9'h000, 8'h01);
    cpu_read(CTRL_SEL, 9'h000);
    run_enables(8 * `H_TOTAL);
    cpu_write(CTRL_SEL, 9'h000, 8'h00);
    cpu_read(CTRL_SEL, 9'h000);
    pix_mark = pix_checks;
    run_enables(8 * `H_TOTAL);
    if (pix_checks == pix_mark)
    begin
        tb_errors++;
        $display("Colour did not come back after force-black was cleared");
    end
    end_test("force black", mark);

    mark = errors + tb_errors;
    while (vcount >= `CNT_W'(`V_ACTIVE - 24))
        @(negedge emu_mclk);
    for (int i = 0; i < 32; i++)
    begin
        repeat (1 + $urandom % 16) @(posedge emu_mclk);
        cpu_write(PAL_SEL, 9'($urandom), 8'($urandom));
    end
    pix_mark = pix_checks;
    run_enables(8 * `H_TOTAL);
    pix_run = 1'b0;
    if (pix_checks == pix_mark)
    begin
        tb_errors++;
        $display("No visible pixel colour was compared after the video-time writes");
    end
    end_test("writes during video", mark);

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
             errors + tb_errors);
    if ((errors + tb_errors == 0) && (tests_failed == 0))
        $display("Simulation PASSED");
    else
        $display("Simulation FAILED");
    $finish;
end

endmodule

//--- test/video_checker.sv
/*
    Testbench checker: raster model, shadow palette and control bit,
    colour pipeline model and every output comparison
*/

`timescale 1ns/1ps

`include "video_defines.svh"

module video_checker
    import video_pkg::*;
(
    input  logic                i_EMU_MCLK,
    input  logic                i_EMU_INITRST_n,
    input  logic [`CPU_AW-1:0]  i_addr,
    input  logic [7:0]          i_data_write,
    input  logic                i_rd_n,
    input  logic                i_wr_n,
    input  logic                i_pal_cs_n,
    input  logic                i_ctrl_cs_n,
    input  logic [`PAL_AW-1:0]  i_obj_pixel,
    input  logic [7:0]          i_data_read,
    input  logic                i_pixel_cen,
    input  raster_cnt_t         i_hcount,
    input  raster_cnt_t         i_vcount,
    input  logic                i_csync_n,
    input  logic                i_hsync_n,
    input  logic                i_vsync_n,
    input  logic                i_hblank_n,
    input  logic                i_vblank_n,
    input  logic [3:0]          i_video_r,
    input  logic [3:0]          i_video_g,
    input  logic [3:0]          i_video_b,
    output int                  o_errors,
    output int                  o_pix_checks    // Visible colours compared
);

// Shadow palette, known only where the CPU wrote it
logic [7:0]     pal_hi [0:255];
logic [7:0]     pal_lo [0:255];
logic           hi_ok  [0:255];
logic           lo_ok  [0:255];

logic           ctrl_m;
logic           phase_m;
logic           cen_m;
raster_cnt_t    h_m;
raster_cnt_t    v_m;
logic [7:0]     idx_m;      // Pixel waiting for its colour
logic           trn_m;
logic           act_m;
logic           taint_m;    // CPU held the RAM during the lookup
logic [3:0]     r_m;
logic [3:0]     g_m;
logic [3:0]     b_m;
logic           rgb_ok;

// Inputs as they stood at the last rising edge
logic           rst_p = 1'b0;
logic           pal_wr_p;
logic           pal_rd_p;
logic           ctrl_wr_p;
logic [8:0]     addr_p;
logic [7:0]     data_p;
logic [7:0]     pix_p;
logic           clocked = 1'b0;

initial
begin
    o_errors     = 0;
    o_pix_checks = 0;
    for (int i = 0; i < 256; i++)
    begin
        hi_ok[i] = 1'b0;
        lo_ok[i] = 1'b0;
    end
end

task automatic mismatch(input string what, input logic [15:0] got, input logic [15:0] exp);
    $display("CHECK FAILED at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    o_errors++;
endtask

//////////////////////////////////////////////////
//////  MODEL STEP FOR THE EDGE JUST PASSED
////

task automatic apply_edge();
    logic show;
    if (!rst_p)
    begin
        ctrl_m  = 1'b0;
        phase_m = 1'b0;
        cen_m   = 1'b0;
        h_m     = '0;
        v_m     = '0;
        idx_m   = 8'h00;
        trn_m   = 1'b0;
        act_m   = 1'b0;
        taint_m = 1'b1;
        r_m     = 4'h0;
        g_m     = 4'h0;
        b_m     = 4'h0;
        rgb_ok  = 1'b1;
    end
    else
    begin
        if (cen_m)
        begin
            // Colour for the pixel of the previous enable
            show   = act_m && !trn_m && !ctrl_m;
            rgb_ok = !show || (!taint_m && hi_ok[idx_m] && lo_ok[idx_m]);
            r_m    = show ? pal_hi[idx_m][7:4] ^ {4{pal_lo[idx_m][2]}} : 4'h0;
            g_m    = show ? pal_hi[idx_m][3:0] ^ {4{pal_lo[idx_m][1]}} : 4'h0;
            b_m    = show ? pal_lo[idx_m][7:4] ^ {4{pal_lo[idx_m][0]}} : 4'h0;
            if (show && rgb_ok)
                o_pix_checks++;

            idx_m   = pix_p;
            trn_m   = (pix_p[3:0] == `TRN_CODE);
            act_m   = (h_m < `CNT_W'(`H_ACTIVE)) && (v_m < `CNT_W'(`V_ACTIVE));
            taint_m = pal_wr_p || pal_rd_p;

            if (h_m == `CNT_W'(`H_TOTAL - 1))
            begin
                h_m = '0;
                v_m = (v_m == `CNT_W'(`V_TOTAL - 1)) ? '0 : v_m + `CNT_W'(1);
            end
            else
                h_m = h_m + `CNT_W'(1);
        end
        else
            taint_m = taint_m || pal_wr_p || pal_rd_p;

        if (ctrl_wr_p)
            ctrl_m = data_p[0];     // Seen from the next enable on
        cen_m   = phase_m;
        phase_m = !phase_m;
    end

    // Palette RAM has no reset
    if (pal_wr_p && addr_p[0])
    begin
        pal_lo[addr_p[8:1]] = data_p;
        lo_ok[addr_p[8:1]]  = 1'b1;
    end
    else if (pal_wr_p)
    begin
        pal_hi[addr_p[8:1]] = data_p;
        hi_ok[addr_p[8:1]]  = 1'b1;
    end
endtask

task automatic compare_outputs();
    logic       hs;
    logic       vs;
    logic [7:0] exp_b;
    logic       b_ok;
    hs = !((h_m >= `CNT_W'(`HSYNC_START)) && (h_m <= `CNT_W'(`HSYNC_END)));
    vs = !((v_m >= `CNT_W'(`VSYNC_START)) && (v_m <= `CNT_W'(`VSYNC_END)));

    if (i_pixel_cen !== cen_m)
        mismatch("pixel enable", 16'(i_pixel_cen), 16'(cen_m));
    if (i_hcount !== h_m)
        mismatch("hcount", 16'(i_hcount), 16'(h_m));
    if (i_vcount !== v_m)
        mismatch("vcount", 16'(i_vcount), 16'(v_m));
    if (i_hsync_n !== hs)
        mismatch("hsync_n", 16'(i_hsync_n), 16'(hs));
    if (i_vsync_n !== vs)
        mismatch("vsync_n", 16'(i_vsync_n), 16'(vs));
    if (i_csync_n !== (hs & vs))
        mismatch("csync_n", 16'(i_csync_n), 16'(hs & vs));
    if (i_hblank_n !== (h_m < `CNT_W'(`H_ACTIVE)))
        mismatch("hblank_n", 16'(i_hblank_n), 16'(h_m < `CNT_W'(`H_ACTIVE)));
    if (i_vblank_n !== (v_m < `CNT_W'(`V_ACTIVE)))
        mismatch("vblank_n", 16'(i_vblank_n), 16'(v_m < `CNT_W'(`V_ACTIVE)));

    if (rgb_ok && ({i_video_r, i_video_g, i_video_b} !== {r_m, g_m, b_m}))
        mismatch("video rgb", 16'({i_video_r, i_video_g, i_video_b}), 16'({r_m, g_m, b_m}));

    if (!i_rd_n && !i_pal_cs_n)
    begin
        // Valid once the RAM has seen the address for a clock
        exp_b = i_addr[0] ? pal_lo[i_addr[8:1]] : pal_hi[i_addr[8:1]];
        b_ok  = i_addr[0] ? lo_ok[i_addr[8:1]] : hi_ok[i_addr[8:1]];
        if (pal_rd_p && (i_addr == addr_p) && b_ok && (i_data_read !== exp_b))
            mismatch("palette read", 16'(i_data_read), 16'(exp_b));
    end
    else if (!i_rd_n && !i_ctrl_cs_n)
    begin
        if (i_data_read !== {7'd0, ctrl_m})
            mismatch("control read", 16'(i_data_read), 16'({7'd0, ctrl_m}));
    end
    else if (i_data_read !== 8'hFF)
        mismatch("idle read data", 16'(i_data_read), 16'h00FF);
endtask

task automatic capture_inputs();
    rst_p     = i_EMU_INITRST_n;
    pal_wr_p  = !i_wr_n && !i_pal_cs_n;
    pal_rd_p  = !i_rd_n && !i_pal_cs_n;
    ctrl_wr_p = !i_wr_n && !i_ctrl_cs_n;
    addr_p    = i_addr;
    data_p    = i_data_write;
    pix_p     = i_obj_pixel;
endtask

always @(posedge i_EMU_MCLK)
    clocked <= 1'b1;

// Mid-cycle, outputs and driven inputs are both settled
always @(negedge i_EMU_MCLK)
begin
    if (clocked)
    begin
        apply_edge();
        compare_outputs();
        capture_inputs();
    end
end

endmodule

//--- verilog/cpu_bus_port.sv
/*
    CPU strobe decode, control register
    and read data mux
*/

`timescale 1ns/1ps

`include "video_defines.svh"

module cpu_bus_port
(
    input  logic                i_EMU_MCLK,
    input  logic                i_EMU_INITRST_n,

    input  logic [`CPU_AW-1:0]  i_addr,
    input  logic [7:0]          i_data_write,
    input  logic                i_rd_n,
    input  logic                i_wr_n,
    input  logic                i_pal_cs_n,
    input  logic                i_ctrl_cs_n,

    output logic [7:0]          o_data_read,
    output logic                o_force_black,

    cpu_palette_if.cpu          cpu
);

// Palette strobes, word address above the byte bit
assign cpu.addr     = i_addr[`CPU_AW-1:1];
assign cpu.byte_sel = i_addr[0];
assign cpu.wdata    = i_data_write;
assign cpu.wr       = !i_pal_cs_n && !i_wr_n;
assign cpu.rd       = !i_pal_cs_n && !i_rd_n;

// Control register, bit 0 is force-black
always_ff @(posedge i_EMU_MCLK)
begin
    if (!i_EMU_INITRST_n)
        o_force_black <= 1'b0;
    else if (!i_ctrl_cs_n && !i_wr_n)
        o_force_black <= i_data_write[0];
end

always_comb
begin
    if (!i_rd_n && !i_pal_cs_n)
        o_data_read = cpu.rdata;
    else if (!i_rd_n && !i_ctrl_cs_n)
        o_data_read = {7'd0, o_force_black};
    else
        o_data_read = 8'hFF;                // Bus pull-up
end

a_single_cs: assert property (@(posedge i_EMU_MCLK) disable iff (!i_EMU_INITRST_n)
    !(!i_pal_cs_n && !i_ctrl_cs_n))
    else $error("palette and control selected together");

endmodule

//--- verilog/palette_arbiter.sv
/*
    Palette RAM arbiter, CPU first
    then pixel lookup, with byte lane steering
*/

`timescale 1ns/1ps

`include "video_defines.svh"

module palette_arbiter
(
    input  logic                i_EMU_MCLK,
    input  logic                i_pixel_cen,
    input  logic [`PAL_AW-1:0]  i_pixel_index,

    cpu_palette_if.arbiter      cpu,
    palette_ram_if.master       ram
);

logic                   cpu_grant;
logic [`PAL_AW-1:0]     lookup_idx_q;

assign cpu_grant = cpu.rd | cpu.wr;

// Hold the index between enables so the RAM output stays on this pixel
always_ff @(posedge i_EMU_MCLK)
begin
    if (i_pixel_cen)
        lookup_idx_q <= i_pixel_index;
end

always_comb
begin
    if (cpu_grant)
        ram.addr = cpu.addr;                // CPU always wins
    else if (i_pixel_cen)
        ram.addr = i_pixel_index;
    else
        ram.addr = lookup_idx_q;
end

// Same byte on both lanes, the enable picks one
always_comb
begin
    ram.wdata.bytes.hi = cpu.wdata;
    ram.wdata.bytes.lo = cpu.wdata;
end

assign ram.we_hi = cpu.wr & ~cpu.byte_sel;
assign ram.we_lo = cpu.wr & cpu.byte_sel;

assign cpu.rdata = cpu.byte_sel ? ram.rdata.bytes.lo : ram.rdata.bytes.hi;

a_one_lane: assert property (@(posedge i_EMU_MCLK)
    (ram.we_hi || ram.we_lo) |-> $onehot({ram.we_hi, ram.we_lo}))
    else $error("both palette byte lanes written");

endmodule

//--- verilog/palette_ifs.sv
/*
    cpu_palette_if: CPU byte access to the palette
    palette_ram_if: word port of the palette RAM
*/

`timescale 1ns/1ps

`include "video_defines.svh"

interface cpu_palette_if;
    logic [`PAL_AW-1:0] addr;
    logic               byte_sel;   // 0 high byte, 1 low byte
    logic [7:0]         wdata;
    logic               wr;
    logic               rd;
    logic [7:0]         rdata;

    modport cpu     (output addr, byte_sel, wdata, wr, rd, input rdata);
    modport arbiter (input addr, byte_sel, wdata, wr, rd, output rdata);
endinterface

interface palette_ram_if
    import video_pkg::*;
;
    logic [`PAL_AW-1:0] addr;
    palette_word_u      wdata;
    logic               we_hi;
    logic               we_lo;
    palette_word_u      rdata;      // Registered read

    modport master (output addr, wdata, we_hi, we_lo, input rdata);
    modport memory (input addr, wdata, we_hi, we_lo, output rdata);
endinterface

//--- verilog/palette_ram.sv
/*
    Palette RAM, 256 x 16
    registered read, byte write enables
*/

`timescale 1ns/1ps

`include "video_defines.svh"

module palette_ram
(
    input  logic            i_EMU_MCLK,
    palette_ram_if.memory   ram
);

localparam int DEPTH = 1 << `PAL_AW;

// One array per byte lane
logic [7:0] mem_hi [0:DEPTH-1];
logic [7:0] mem_lo [0:DEPTH-1];

always_ff @(posedge i_EMU_MCLK)
begin
    if (ram.we_hi)
        mem_hi[ram.addr] <= ram.wdata.bytes.hi;
    if (ram.we_lo)
        mem_lo[ram.addr] <= ram.wdata.bytes.lo;

    ram.rdata.bytes.hi <= mem_hi[ram.addr];     // Old data on a write
    ram.rdata.bytes.lo <= mem_lo[ram.addr];
end

endmodule

//--- verilog/palette_video_top.sv
/*
    Video output stage top: timing, CPU port,
    palette RAM with arbiter, colour output
*/

`timescale 1ns/1ps

`include "video_defines.svh"

module palette_video_top
    import video_pkg::*;
(
    input  logic                i_EMU_MCLK,
    input  logic                i_EMU_INITRST_n,

    // CPU side
    input  logic [`CPU_AW-1:0]  i_addr,
    input  logic [7:0]          i_data_write,
    output logic [7:0]          o_data_read,
    input  logic                i_rd_n,
    input  logic                i_wr_n,
    input  logic                i_pal_cs_n,
    input  logic                i_ctrl_cs_n,

    input  logic [`PAL_AW-1:0]  i_obj_pixel,    // Sprite pixel index

    // Raster
    output logic                o_pixel_cen,
    output raster_cnt_t         o_hcount,
    output raster_cnt_t         o_vcount,
    output logic                o_csync_n,
    output logic                o_hsync_n,
    output logic                o_vsync_n,
    output logic                o_hblank_n,
    output logic                o_vblank_n,

    output logic [3:0]          o_video_r,
    output logic [3:0]          o_video_g,
    output logic [3:0]          o_video_b
);

cpu_palette_if  cpu_bus ();
palette_ram_if  ram_bus ();

logic force_black;

//////////////////////////////////////////////////
//////  INSTANCES
////

video_timing u_video_timing (
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_EMU_INITRST_n    (i_EMU_INITRST_n    ),
    .o_pixel_cen        (o_pixel_cen        ),
    .o_hcount           (o_hcount           ),
    .o_vcount           (o_vcount           ),
    .o_hsync_n          (o_hsync_n          ),
    .o_vsync_n          (o_vsync_n          ),
    .o_csync_n          (o_csync_n          ),
    .o_hblank_n         (o_hblank_n         ),
    .o_vblank_n         (o_vblank_n         )
);

cpu_bus_port u_cpu_bus_port (
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_EMU_INITRST_n    (i_EMU_INITRST_n    ),
    .i_addr             (i_addr             ),
    .i_data_write       (i_data_write       ),
    .i_rd_n             (i_rd_n             ),
    .i_wr_n             (i_wr_n             ),
    .i_pal_cs_n         (i_pal_cs_n         ),
    .i_ctrl_cs_n        (i_ctrl_cs_n        ),
    .o_data_read        (o_data_read        ),
    .o_force_black      (force_black        ),
    .cpu                (cpu_bus            )
);

palette_arbiter u_palette_arbiter (
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_pixel_cen        (o_pixel_cen        ),
    .i_pixel_index      (i_obj_pixel        ),
    .cpu                (cpu_bus            ),
    .ram                (ram_bus            )
);

palette_ram u_palette_ram (
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .ram                (ram_bus            )
);

pixel_color_out u_pixel_color_out (
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_EMU_INITRST_n    (i_EMU_INITRST_n    ),
    .i_pixel_cen        (o_pixel_cen        ),
    .i_pixel_index      (i_obj_pixel        ),
    .i_hcount           (o_hcount           ),
    .i_vcount           (o_vcount           ),
    .i_force_black      (force_black        ),
    .i_pal_word         (ram_bus.rdata      ),
    .o_video_r          (o_video_r          ),
    .o_video_g          (o_video_g          ),
    .o_video_b          (o_video_b          )
);

endmodule

//--- verilog/pixel_color_out.sv
/*
    Video output latch: transparency, per-channel invert,
    blanking and force-black
*/

`timescale 1ns/1ps

`include "video_defines.svh"

module pixel_color_out
    import video_pkg::*;
(
    input  logic                i_EMU_MCLK,
    input  logic                i_EMU_INITRST_n,

    input  logic                i_pixel_cen,
    input  logic [`PAL_AW-1:0]  i_pixel_index,
    input  raster_cnt_t         i_hcount,
    input  raster_cnt_t         i_vcount,
    input  logic                i_force_black,
    input  palette_word_u       i_pal_word,

    output logic [3:0]          o_video_r,
    output logic [3:0]          o_video_g,
    output logic [3:0]          o_video_b
);

logic trn_q;        // Pixel one enable back was transparent
logic active_q;     // ...and was inside the active area
logic show;

assign show = active_q && !trn_q && !i_force_black;

//////////////////////////////////////////////////
//////  OUTPUT LATCH
////

always_ff @(posedge i_EMU_MCLK)
begin
    if (!i_EMU_INITRST_n)
    begin
        trn_q     <= 1'b0;
        active_q  <= 1'b0;
        o_video_r <= 4'h0;
        o_video_g <= 4'h0;
        o_video_b <= 4'h0;
    end
    else if (i_pixel_cen)
    begin
        trn_q    <= (i_pixel_index[3:0] == `TRN_CODE);
        active_q <= (i_hcount < `CNT_W'(`H_ACTIVE)) && (i_vcount < `CNT_W'(`V_ACTIVE));

        // RAM output now holds the entry looked up last enable
        if (show)
        begin
            o_video_r <= i_pal_word.color.red   ^ {4{i_pal_word.color.invert_r}};
            o_video_g <= i_pal_word.color.green ^ {4{i_pal_word.color.invert_g}};
            o_video_b <= i_pal_word.color.blue  ^ {4{i_pal_word.color.invert_b}};
        end
        else
        begin
            o_video_r <= 4'h0;
            o_video_g <= 4'h0;
            o_video_b <= 4'h0;
        end
    end
end

endmodule

//--- verilog/video_defines.svh
/*
    Raster sizes, sync windows, bus widths
    and the transparent pixel code of the video stage
*/

`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Raster geometry in pixels and lines
`define H_TOTAL         384
`define V_TOTAL         264
`define H_ACTIVE        256
`define V_ACTIVE        224

// Sync pulses, low between start and end inclusive
`define HSYNC_START     300
`define HSYNC_END       331
`define VSYNC_START     240
`define VSYNC_END       247

`define CNT_W           9       // Raster counter width
`define PAL_AW          8       // Palette index width
`define CPU_AW          9       // CPU address, bit 0 picks the byte

`define TRN_CODE        4'hF    // Low nibble that means transparent

`endif

//--- verilog/video_pkg.sv
/*
    Shared types: raster count and palette word
    with its colour and CPU byte views
*/

`include "video_defines.svh"

package video_pkg;

    typedef logic [`CNT_W-1:0] raster_cnt_t;

    // Colour view, as the video path decodes it
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
        logic       spare;
        logic       invert_r;
        logic       invert_g;
        logic       invert_b;
    } palette_color_t;

    // Byte view, as the CPU sees it
    typedef struct packed {
        logic [7:0] hi;         // Even address
        logic [7:0] lo;         // Odd address
    } palette_bytes_t;

    typedef union packed {
        palette_color_t color;
        palette_bytes_t bytes;
    } palette_word_u;

endpackage

//--- verilog/video_timing.sv
/*
    Pixel clock enable, horizontal and vertical raster counters,
    sync and blanking decode
*/

`timescale 1ns/1ps

`include "video_defines.svh"

module video_timing
    import video_pkg::*;
(
    input  logic        i_EMU_MCLK,
    input  logic        i_EMU_INITRST_n,

    output logic        o_pixel_cen,
    output raster_cnt_t o_hcount,
    output raster_cnt_t o_vcount,

    output logic        o_hsync_n,
    output logic        o_vsync_n,
    output logic        o_csync_n,
    output logic        o_hblank_n,
    output logic        o_vblank_n
);

//////////////////////////////////////////////////
//////  PIXEL ENABLE
////

logic phase_q;

// MCLK/2 enable with one clock of phase before the first high
always_ff @(posedge i_EMU_MCLK)
begin
    if (!i_EMU_INITRST_n)
    begin
        phase_q     <= 1'b0;
        o_pixel_cen <= 1'b0;
    end
    else
    begin
        phase_q     <= ~phase_q;
        o_pixel_cen <= phase_q;
    end
end

//////////////////////////////////////////////////
//////  RASTER COUNTERS
////

logic h_last;
logic v_last;

assign h_last = (o_hcount == `CNT_W'(`H_TOTAL - 1));
assign v_last = (o_vcount == `CNT_W'(`V_TOTAL - 1));

always_ff @(posedge i_EMU_MCLK)
begin
    if (!i_EMU_INITRST_n)
    begin
        o_hcount <= '0;
        o_vcount <= '0;
    end
    else if (o_pixel_cen)
    begin
        if (h_last)
        begin
            o_hcount <= '0;
            o_vcount <= v_last ? '0 : o_vcount + 1'b1;    // Line done
        end
        else
        begin
            o_hcount <= o_hcount + 1'b1;
        end
    end
end

// Sync windows and active area straight off the counts
assign o_hsync_n  = !((o_hcount >= `CNT_W'(`HSYNC_START)) && (o_hcount <= `CNT_W'(`HSYNC_END)));
assign o_vsync_n  = !((o_vcount >= `CNT_W'(`VSYNC_START)) && (o_vcount <= `CNT_W'(`VSYNC_END)));
assign o_csync_n  = o_hsync_n & o_vsync_n;
assign o_hblank_n = (o_hcount < `CNT_W'(`H_ACTIVE));
assign o_vblank_n = (o_vcount < `CNT_W'(`V_ACTIVE));

a_count_range: assert property (@(posedge i_EMU_MCLK) disable iff (!i_EMU_INITRST_n)
    (o_hcount < `CNT_W'(`H_TOTAL)) && (o_vcount < `CNT_W'(`V_TOTAL)))
    else $error("raster count out of range h=%0d v=%0d", o_hcount, o_vcount);

endmodule
